/* common/gtePkg.sv */
// Shared IDs, widths and port structs for the GTE register file
// Only FLAGS is kept in control space, so any ID with bit 5 set reads FLAGS
// ID 23 (RES1) is not implemented and reads zero

package gtePkg;

	// ------------------------------------------------------------
	// Widths and depths
	// ------------------------------------------------------------
	localparam int DATA_W      = 32;  // CPU word
	localparam int HALF_W      = 16;  // Short register
	localparam int CHAN_W      = 8;   // One color channel
	localparam int FLAG_W      = 19;  // Stored flag bits
	localparam int FLAG_LSB    = 12;  // Flags sit at 30..12 of the word
	localparam int XY_DEPTH    = 3;
	localparam int Z_DEPTH     = 4;   // SZ0..SZ2 plus SZP
	localparam int COLOR_DEPTH = 3;
	localparam int IRGB_SHIFT  = 7;   // 5-bit color <-> IR scaling
	localparam int COL5_W      = 5;

	// ------------------------------------------------------------
	// Register IDs
	// ------------------------------------------------------------
	typedef enum logic [5:0] {
		VXY0  = 6'd0,
		VZ0   = 6'd1,
		VXY1  = 6'd2,
		VZ1   = 6'd3,
		VXY2  = 6'd4,
		VZ2   = 6'd5,
		RGBC  = 6'd6,
		OTZ   = 6'd7,
		IR0   = 6'd8,
		IR1   = 6'd9,
		IR2   = 6'd10,
		IR3   = 6'd11,
		SXY0  = 6'd12,
		SXY1  = 6'd13,
		SXY2  = 6'd14,
		SXYP  = 6'd15,
		SZ0   = 6'd16,
		SZ1   = 6'd17,
		SZ2   = 6'd18,
		SZP   = 6'd19,
		RGB0  = 6'd20,
		RGB1  = 6'd21,
		RGB2  = 6'd22,
		MAC0  = 6'd24,  // 23 is the old RES1 slot
		MAC1  = 6'd25,
		MAC2  = 6'd26,
		MAC3  = 6'd27,
		IRGB  = 6'd28,
		ORGB  = 6'd29,
		LZCS  = 6'd30,
		LZCR  = 6'd31,
		FLAGS = 6'd63
	} gteRegId_e;

	// Color word, code in the top byte
	typedef struct packed {
		logic [CHAN_W-1:0] code;
		logic [CHAN_W-1:0] b;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] r;
	} gteColor_t;

	// Writeback from the compute unit
	typedef struct packed {
		logic              pushX;
		logic              pushY;
		logic              pushZ;
		logic              pushR;
		logic              pushG;
		logic              pushB;
		logic [3:0]        wrIr;        // IR0..IR3
		logic [3:0]        wrMac;       // MAC0..MAC3
		logic              wrOtz;
		logic              loadInstr;   // Instruction start, FLAGS reload
		logic [CHAN_W-1:0] colV;
		logic [HALF_W-1:0] xyV;
		logic [HALF_W-1:0] otzV;        // Also feeds the SZ push
		logic [HALF_W-1:0] ir0;
		logic [HALF_W-1:0] ir13;
		logic [DATA_W-1:0] mac0;
		logic [DATA_W-1:0] mac13;
		logic [FLAG_W-1:0] updateFlags;
	} gteWb_t;

	// One CPU write enable per writable ID
	typedef struct packed {
		logic [2:0]             vxy;
		logic [2:0]             vz;
		logic                   rgbc;
		logic                   otz;
		logic [3:0]             ir;
		logic [XY_DEPTH-1:0]    sxy;
		logic                   sxyp;   // Push into SX and SY
		logic [Z_DEPTH-1:0]     sz;     // Bit 3 is SZP
		logic [COLOR_DEPTH-1:0] rgb;
		logic [3:0]             mac;
		logic                   irgb;
		logic                   lzcs;
		logic                   flags;
	} gteWrEn_t;

endpackage

/* source/gteShiftFifo.sv */
// One lane of a shifting FIFO, slot 0 is the oldest entry
// A push shifts toward slot 0 and overrides any slot write in the same cycle

`timescale 1ns/1ps

module gteShiftFifo #(
	parameter type tEntry = logic [15:0],
	parameter int  DEPTH  = 3
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_push,
	input  tEntry            i_pushData,
	input  logic [DEPTH-1:0] i_slotWr,     // CPU slot load
	input  tEntry            i_slotData,
	output tEntry            o_slots [DEPTH]
);

	tEntry slots [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int k = 0; k < DEPTH; k++) begin
				slots[k] <= '0;
			end
		end else if (i_push) begin
			for (int k = 0; k < DEPTH - 1; k++) begin
				slots[k] <= slots[k + 1];  // Age by one
			end
			slots[DEPTH-1] <= i_pushData;  // Newest on top
		end else begin
			for (int k = 0; k < DEPTH; k++) begin
				if (i_slotWr[k]) slots[k] <= i_slotData;
			end
		end
	end

	assign o_slots = slots;

endmodule

/* source/gteRegDecode.sv */
// CPU write decode, all enables are zero unless i_wrReg is high
// Read-only IDs (ORGB, LZCR) and unknown IDs produce no enable

`timescale 1ns/1ps

module gteRegDecode (
	input  gtePkg::gteRegId_e i_regId,
	input  logic              i_wrReg,
	output gtePkg::gteWrEn_t  o_wrEn
);

	import gtePkg::*;

	gteWrEn_t hit;  // ID match before the strobe

	always_comb begin
		hit.vxy   = {i_regId == VXY2, i_regId == VXY1, i_regId == VXY0};
		hit.vz    = {i_regId == VZ2, i_regId == VZ1, i_regId == VZ0};
		hit.rgbc  = (i_regId == RGBC);
		hit.otz   = (i_regId == OTZ);
		hit.ir    = {i_regId == IR3, i_regId == IR2, i_regId == IR1, i_regId == IR0};
		// Screen FIFO slots
		hit.sxy   = {i_regId == SXY2, i_regId == SXY1, i_regId == SXY0};
		hit.sxyp  = (i_regId == SXYP);
		hit.sz    = {i_regId == SZP, i_regId == SZ2, i_regId == SZ1, i_regId == SZ0};
		// Color FIFO slots
		hit.rgb   = {i_regId == RGB2, i_regId == RGB1, i_regId == RGB0};
		hit.mac   = {i_regId == MAC3, i_regId == MAC2, i_regId == MAC1, i_regId == MAC0};
		hit.irgb  = (i_regId == IRGB);
		hit.lzcs  = (i_regId == LZCS);
		hit.flags = (i_regId == FLAGS);
	end

	assign o_wrEn = i_wrReg ? hit : '0;

endmodule

/* screen/gteScreenFifo.sv */
// SX/SY/SZ screen coordinate FIFOs
// CPU SXYP push beats a writeback push of xyV in the same cycle
// SZ only shifts on pushZ, the CPU can load any of its four slots

`timescale 1ns/1ps

module gteScreenFifo (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  gtePkg::gteWrEn_t           i_wrEn,
	input  logic [gtePkg::DATA_W-1:0]  i_dataIn,
	input  gtePkg::gteWb_t             i_wb,
	output logic [gtePkg::HALF_W-1:0]  o_sx [gtePkg::XY_DEPTH],
	output logic [gtePkg::HALF_W-1:0]  o_sy [gtePkg::XY_DEPTH],
	output logic [gtePkg::HALF_W-1:0]  o_sz [gtePkg::Z_DEPTH]
);

	import gtePkg::*;

	logic              pushX;
	logic              pushY;
	logic [HALF_W-1:0] pushDataX;
	logic [HALF_W-1:0] pushDataY;

	// ------------------------------------------------------------
	// Push source select
	// ------------------------------------------------------------
	assign pushX     = i_wrEn.sxyp | i_wb.pushX;
	assign pushY     = i_wrEn.sxyp | i_wb.pushY;
	assign pushDataX = i_wrEn.sxyp ? i_dataIn[HALF_W-1:0] : i_wb.xyV;       // Low half
	assign pushDataY = i_wrEn.sxyp ? i_dataIn[DATA_W-1:HALF_W] : i_wb.xyV;  // High half

	gteShiftFifo #(.tEntry(logic [HALF_W-1:0]), .DEPTH(XY_DEPTH)) u_sxFifo (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_push     (pushX),
		.i_pushData (pushDataX),
		.i_slotWr   (i_wrEn.sxy),
		.i_slotData (i_dataIn[HALF_W-1:0]),
		.o_slots    (o_sx)
	);

	gteShiftFifo #(.tEntry(logic [HALF_W-1:0]), .DEPTH(XY_DEPTH)) u_syFifo (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_push     (pushY),
		.i_pushData (pushDataY),
		.i_slotWr   (i_wrEn.sxy),
		.i_slotData (i_dataIn[DATA_W-1:HALF_W]),
		.o_slots    (o_sy)
	);

	// Z lane, writeback push only
	gteShiftFifo #(.tEntry(logic [HALF_W-1:0]), .DEPTH(Z_DEPTH)) u_szFifo (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_push     (i_wb.pushZ),
		.i_pushData (i_wb.otzV),
		.i_slotWr   (i_wrEn.sz),
		.i_slotData (i_dataIn[HALF_W-1:0]),
		.o_slots    (o_sz)
	);

endmodule

/* color/gteColorFifo.sv */
// Color FIFO, one lane per channel plus a code lane that moves with blue
// CPU writes load a whole slot, pushes come from the compute unit only

`timescale 1ns/1ps

module gteColorFifo (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  gtePkg::gteWrEn_t          i_wrEn,
	input  logic [gtePkg::DATA_W-1:0] i_dataIn,
	input  gtePkg::gteWb_t            i_wb,
	output gtePkg::gteColor_t         o_rgb [gtePkg::COLOR_DEPTH],
	output gtePkg::gteColor_t         o_rgbc
);

	import gtePkg::*;

	gteColor_t         cpuCol;    // CPU word split into channels
	gteColor_t         rgbc;
	logic [CHAN_W-1:0] rSlot    [COLOR_DEPTH];
	logic [CHAN_W-1:0] gSlot    [COLOR_DEPTH];
	logic [CHAN_W-1:0] bSlot    [COLOR_DEPTH];
	logic [CHAN_W-1:0] codeSlot [COLOR_DEPTH];

	assign cpuCol = i_dataIn;

	// RGBC code register, CPU only
	always_ff @(posedge i_clk) begin
		if (i_rst) rgbc <= '0;
		else if (i_wrEn.rgbc) rgbc <= cpuCol;
	end

	gteShiftFifo #(.tEntry(logic [CHAN_W-1:0]), .DEPTH(COLOR_DEPTH)) u_rFifo (
		.i_clk(i_clk), .i_rst(i_rst), .i_push(i_wb.pushR), .i_pushData(i_wb.colV),
		.i_slotWr(i_wrEn.rgb), .i_slotData(cpuCol.r), .o_slots(rSlot)
	);
	gteShiftFifo #(.tEntry(logic [CHAN_W-1:0]), .DEPTH(COLOR_DEPTH)) u_gFifo (
		.i_clk(i_clk), .i_rst(i_rst), .i_push(i_wb.pushG), .i_pushData(i_wb.colV),
		.i_slotWr(i_wrEn.rgb), .i_slotData(cpuCol.g), .o_slots(gSlot)
	);
	gteShiftFifo #(.tEntry(logic [CHAN_W-1:0]), .DEPTH(COLOR_DEPTH)) u_bFifo (
		.i_clk(i_clk), .i_rst(i_rst), .i_push(i_wb.pushB), .i_pushData(i_wb.colV),
		.i_slotWr(i_wrEn.rgb), .i_slotData(cpuCol.b), .o_slots(bSlot)
	);
	// Code lane shifts on blue, new entry takes RGBC code
	gteShiftFifo #(.tEntry(logic [CHAN_W-1:0]), .DEPTH(COLOR_DEPTH)) u_codeFifo (
		.i_clk(i_clk), .i_rst(i_rst), .i_push(i_wb.pushB), .i_pushData(rgbc.code),
		.i_slotWr(i_wrEn.rgb), .i_slotData(cpuCol.code), .o_slots(codeSlot)
	);

	always_comb begin
		for (int k = 0; k < COLOR_DEPTH; k++) begin
			o_rgb[k].code = codeSlot[k];
			o_rgb[k].b    = bSlot[k];
			o_rgb[k].g    = gSlot[k];
			o_rgb[k].r    = rSlot[k];
		end
	end

	assign o_rgbc = rgbc;

endmodule

/* source/gteResultRegs.sv */
// IR, MAC, OTZ and FLAGS, written by CPU and by the compute unit
// Writeback wins over a CPU write, except on FLAGS where the CPU wins
// FLAGS accumulates updateFlags every cycle unless reloaded or written

`timescale 1ns/1ps

module gteResultRegs (
	input  logic                            i_clk,
	input  logic                            i_rst,
	input  gtePkg::gteWrEn_t                i_wrEn,
	input  logic [gtePkg::DATA_W-1:0]       i_dataIn,
	input  gtePkg::gteWb_t                  i_wb,
	output logic [3:0][gtePkg::HALF_W-1:0]  o_ir,
	output logic [3:0][gtePkg::DATA_W-1:0]  o_mac,
	output logic [gtePkg::HALF_W-1:0]       o_otz,
	output logic [gtePkg::FLAG_W-1:0]       o_flags
);

	import gtePkg::*;

	logic [3:1][HALF_W-1:0] irgbExp;  // IRGB fields scaled to IR1..IR3

	// 5-bit fields at 4..0, 9..5, 14..10, shifted up by 7
	always_comb begin
		for (int k = 1; k <= 3; k++) begin
			irgbExp[k] = HALF_W'(i_dataIn[(k-1)*COL5_W +: COL5_W]) << IRGB_SHIFT;
		end
	end

	// ------------------------------------------------------------
	// Register update
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_ir    <= '0;
			o_mac   <= '0;
			o_otz   <= '0;
			o_flags <= '0;
		end else begin
			// IR0 has its own writeback bus
			if (i_wb.wrIr[0]) o_ir[0] <= i_wb.ir0;
			else if (i_wrEn.ir[0]) o_ir[0] <= i_dataIn[HALF_W-1:0];
			for (int k = 1; k <= 3; k++) begin
				if (i_wb.wrIr[k]) o_ir[k] <= i_wb.ir13;
				else if (i_wrEn.irgb) o_ir[k] <= irgbExp[k];
				else if (i_wrEn.ir[k]) o_ir[k] <= i_dataIn[HALF_W-1:0];
			end

			if (i_wb.wrMac[0]) o_mac[0] <= i_wb.mac0;
			else if (i_wrEn.mac[0]) o_mac[0] <= i_dataIn;
			for (int k = 1; k <= 3; k++) begin
				if (i_wb.wrMac[k]) o_mac[k] <= i_wb.mac13;
				else if (i_wrEn.mac[k]) o_mac[k] <= i_dataIn;
			end

			if (i_wb.wrOtz) o_otz <= i_wb.otzV;
			else if (i_wrEn.otz) o_otz <= i_dataIn[HALF_W-1:0];

			if (i_wrEn.flags) o_flags <= i_dataIn[FLAG_LSB +: FLAG_W];  // Bits 30..12
			else if (i_wb.loadInstr) o_flags <= i_wb.updateFlags;     // New instruction
			else o_flags <= o_flags | i_wb.updateFlags;               // Sticky
		end
	end

endmodule

/* source/gteInputRegs.sv */
// CPU-only input vectors V0..V2 and the leading-count source word

`timescale 1ns/1ps

module gteInputRegs (
	input  logic                            i_clk,
	input  logic                            i_rst,
	input  gtePkg::gteWrEn_t                i_wrEn,
	input  logic [gtePkg::DATA_W-1:0]       i_dataIn,
	output logic [2:0][gtePkg::HALF_W-1:0]  o_vx,
	output logic [2:0][gtePkg::HALF_W-1:0]  o_vy,
	output logic [2:0][gtePkg::HALF_W-1:0]  o_vz,
	output logic [gtePkg::DATA_W-1:0]       o_lzcs
);

	import gtePkg::*;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_vx   <= '0;
			o_vy   <= '0;
			o_vz   <= '0;
			o_lzcs <= '0;
		end else begin
			for (int n = 0; n < 3; n++) begin
				if (i_wrEn.vxy[n]) begin
					o_vy[n] <= i_dataIn[DATA_W-1:HALF_W];  // Y high
					o_vx[n] <= i_dataIn[HALF_W-1:0];       // X low
				end
				if (i_wrEn.vz[n]) o_vz[n] <= i_dataIn[HALF_W-1:0];
			end
			if (i_wrEn.lzcs) o_lzcs <= i_dataIn;
		end
	end

endmodule

/* source/gteReadMux.sv */
// CPU read path, purely combinational from ID and register contents
// Any ID with bit 5 set returns the FLAGS word, unmapped data IDs return 0

`timescale 1ns/1ps

module gteReadMux (
	input  gtePkg::gteRegId_e               i_regId,
	input  logic [2:0][gtePkg::HALF_W-1:0]  i_vx,
	input  logic [2:0][gtePkg::HALF_W-1:0]  i_vy,
	input  logic [2:0][gtePkg::HALF_W-1:0]  i_vz,
	input  logic [gtePkg::HALF_W-1:0]       i_sx [gtePkg::XY_DEPTH],
	input  logic [gtePkg::HALF_W-1:0]       i_sy [gtePkg::XY_DEPTH],
	input  logic [gtePkg::HALF_W-1:0]       i_sz [gtePkg::Z_DEPTH],
	input  gtePkg::gteColor_t               i_rgb [gtePkg::COLOR_DEPTH],
	input  gtePkg::gteColor_t               i_rgbc,
	input  logic [3:0][gtePkg::HALF_W-1:0]  i_ir,
	input  logic [3:0][gtePkg::DATA_W-1:0]  i_mac,
	input  logic [gtePkg::HALF_W-1:0]       i_otz,
	input  logic [gtePkg::FLAG_W-1:0]       i_flags,
	input  logic [gtePkg::DATA_W-1:0]       i_lzcs,
	output logic [gtePkg::DATA_W-1:0]       o_dataOut
);

	import gtePkg::*;

	logic [1:0]          sel;       // Index within a register group
	logic [1:0]          vecSel;    // V0..V2 from ID 0..5
	logic                flag31;
	logic [DATA_W-1:0]   lzcX;      // Leading bits turned into zeros
	logic [5:0]          lzcCnt;    // 1..32
	logic [3*COL5_W-1:0] col15;

	function automatic logic [DATA_W-1:0] sext(input logic [HALF_W-1:0] v);
		return {{(DATA_W-HALF_W){v[HALF_W-1]}}, v};
	endfunction

	// IR >> 7 clamped into 0..31
	function automatic logic [COL5_W-1:0] sat5(input logic [HALF_W-1:0] v);
		logic signed [HALF_W-1:0] s;
		s = $signed(v) >>> IRGB_SHIFT;
		if (s < 0) return '0;
		else if (s > (2**COL5_W - 1)) return '1;
		else return s[COL5_W-1:0];
	endfunction

	assign sel    = i_regId[1:0];
	assign vecSel = i_regId[2:1];
	assign flag31 = (|i_flags[18:11]) | (|i_flags[6:1]);  // Error summary
	assign col15  = {sat5(i_ir[3]), sat5(i_ir[2]), sat5(i_ir[1])};

	// ------------------------------------------------------------
	// Leading count, bit 31 always counts
	// ------------------------------------------------------------
	assign lzcX = i_lzcs ^ {DATA_W{i_lzcs[DATA_W-1]}};

	always_comb begin
		lzcCnt = 6'(DATA_W);
		for (int b = 0; b < DATA_W; b++) begin
			if (lzcX[b]) lzcCnt = 6'(DATA_W - 1 - b);  // Highest set bit wins
		end
	end

	always_comb begin
		if (i_regId[5]) begin
			o_dataOut = {flag31, i_flags, {FLAG_LSB{1'b0}}};
		end else begin
			case (i_regId)
				VXY0, VXY1, VXY2 : o_dataOut = {i_vy[vecSel], i_vx[vecSel]};
				VZ0, VZ1, VZ2    : o_dataOut = sext(i_vz[vecSel]);
				RGBC             : o_dataOut = i_rgbc;
				OTZ              : o_dataOut = DATA_W'(i_otz);
				IR0, IR1, IR2, IR3         : o_dataOut = sext(i_ir[sel]);
				SXY0, SXY1, SXY2           : o_dataOut = {i_sy[sel], i_sx[sel]};
				SXYP             : o_dataOut = {i_sy[XY_DEPTH-1], i_sx[XY_DEPTH-1]};  // Newest
				SZ0, SZ1, SZ2, SZP         : o_dataOut = DATA_W'(i_sz[sel]);   // SZP is SZ3
				RGB0, RGB1, RGB2           : o_dataOut = i_rgb[sel];
				MAC0, MAC1, MAC2, MAC3     : o_dataOut = i_mac[sel];
				IRGB, ORGB       : o_dataOut = DATA_W'(col15);
				LZCS             : o_dataOut = i_lzcs;
				LZCR             : o_dataOut = DATA_W'(lzcCnt);
				default          : o_dataOut = '0;
			endcase
		end
	end

endmodule

/* source/gteRegFile.sv */
// GTE register file top, writes land on the sampling edge
// Reads are combinational, no handshake and no back-pressure

`timescale 1ns/1ps

module gteRegFile (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  gtePkg::gteRegId_e         i_regId,
	input  logic                      i_wrReg,
	input  logic [gtePkg::DATA_W-1:0] i_dataIn,
	input  gtePkg::gteWb_t            i_wb,
	output logic [gtePkg::DATA_W-1:0] o_dataOut
);

	import gtePkg::*;

	gteWrEn_t               wrEn;
	logic [2:0][HALF_W-1:0] vx;
	logic [2:0][HALF_W-1:0] vy;
	logic [2:0][HALF_W-1:0] vz;
	logic [DATA_W-1:0]      lzcs;
	logic [HALF_W-1:0]      sx [XY_DEPTH];
	logic [HALF_W-1:0]      sy [XY_DEPTH];
	logic [HALF_W-1:0]      sz [Z_DEPTH];
	gteColor_t              rgb [COLOR_DEPTH];
	gteColor_t              rgbc;
	logic [3:0][HALF_W-1:0] ir;
	logic [3:0][DATA_W-1:0] mac;
	logic [HALF_W-1:0]      otz;
	logic [FLAG_W-1:0]      flags;

	gteRegDecode u_decode (.i_regId(i_regId), .i_wrReg(i_wrReg), .o_wrEn(wrEn));

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------
	gteScreenFifo u_screen (.i_clk(i_clk), .i_rst(i_rst), .i_wrEn(wrEn), .i_dataIn(i_dataIn),
		.i_wb(i_wb), .o_sx(sx), .o_sy(sy), .o_sz(sz));
	gteColorFifo u_color (.i_clk(i_clk), .i_rst(i_rst), .i_wrEn(wrEn), .i_dataIn(i_dataIn),
		.i_wb(i_wb), .o_rgb(rgb), .o_rgbc(rgbc));
	gteResultRegs u_result (.i_clk(i_clk), .i_rst(i_rst), .i_wrEn(wrEn), .i_dataIn(i_dataIn),
		.i_wb(i_wb), .o_ir(ir), .o_mac(mac), .o_otz(otz), .o_flags(flags));
	gteInputRegs u_input (.i_clk(i_clk), .i_rst(i_rst), .i_wrEn(wrEn), .i_dataIn(i_dataIn),
		.o_vx(vx), .o_vy(vy), .o_vz(vz), .o_lzcs(lzcs));

	// CPU read back
	gteReadMux u_readMux (
		.i_regId   (i_regId),
		.i_vx      (vx),
		.i_vy      (vy),
		.i_vz      (vz),
		.i_sx      (sx),
		.i_sy      (sy),
		.i_sz      (sz),
		.i_rgb     (rgb),
		.i_rgbc    (rgbc),
		.i_ir      (ir),
		.i_mac     (mac),
		.i_otz     (otz),
		.i_flags   (flags),
		.i_lzcs    (lzcs),
		.o_dataOut (o_dataOut)
	);

endmodule

/* dv/tbClock.sv */
// Testbench clock and reset source, reset held high from time zero
// Reset drops on a falling edge so it never races the DUT sampling edge

`timescale 1ns/1ps

module tbClock #(
	parameter real PERIOD_NS  = 8.0,
	parameter int  RST_CYCLES = 16
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;  // 125 MHz
	end

	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst = 1'b0;
	end

endmodule

/* dv/gteRegFileTb.sv */
// Self-checking testbench for the GTE register file
// Model is updated on each rising edge, reads are sampled 2 ns after the falling edge
// Random data from a 32-bit Galois LFSR, one step per bit taken

`timescale 1ns/1ps

module gteRegFileTb;

	import gtePkg::*;

	// About 16 reset + 4 full sweeps of 33 reads + ~170 single accesses
	localparam int TEST_CYCLES    = 320;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic              clk;
	logic              rst;
	gteRegId_e         i_regId;
	logic              i_wrReg;
	logic [DATA_W-1:0] i_dataIn;
	gteWb_t            i_wb;
	logic [DATA_W-1:0] o_dataOut;

	int          nErrors;
	int          nChecks;
	int          cycles;
	logic [31:0] lfsr;

	// Reference model state
	logic [15:0] mVx [3];
	logic [15:0] mVy [3];
	logic [15:0] mVz [3];
	logic [15:0] mSx [3];
	logic [15:0] mSy [3];
	logic [15:0] mSz [4];
	logic [7:0]  mCol [4][3];  // Lanes r, g, b, code
	logic [31:0] mRgbc;
	logic [15:0] mIr [4];
	logic [31:0] mMac [4];
	logic [15:0] mOtz;
	logic [18:0] mFlags;
	logic [31:0] mLzcs;

	tbClock #(.PERIOD_NS(8.0), .RST_CYCLES(16)) u_tbClock (.o_clk(clk), .o_rst(rst));

	gteRegFile u_gteRegFile (
		.i_clk     (clk),
		.i_rst     (rst),
		.i_regId   (i_regId),
		.i_wrReg   (i_wrReg),
		.i_dataIn  (i_dataIn),
		.i_wb      (i_wb),
		.o_dataOut (o_dataOut)
	);

	// ------------------------------------------------------------
	// Random source and helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] rnd(input int nBits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nBits; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic gteWb_t randWb();
		logic [$bits(gteWb_t)-1:0] bits;  // Whole writeback struct
		for (int i = 0; i < $bits(gteWb_t); i++) begin
			bits[i] = rnd(1) != 0;
		end
		return bits;
	endfunction

	// IR >> 7, clamped into 0..31
	function automatic logic [4:0] clamp5(input logic [15:0] v);
		int s;
		s = int'($signed(v)) >>> 7;
		if (s < 0) return 5'd0;
		if (s > 31) return 5'd31;
		return s[4:0];
	endfunction

	// Leading bits equal to bit 31
	function automatic logic [31:0] leadCount(input logic [31:0] v);
		int  n;
		logic run;
		n = 0;
		run = 1'b1;
		for (int b = 31; b >= 0; b--) begin
			if (run && v[b] == v[31]) n++;
			else run = 1'b0;
		end
		return n;
	endfunction

	task automatic clearModel();
		for (int k = 0; k < 3; k++) begin
			mVx[k] = '0;
			mVy[k] = '0;
			mVz[k] = '0;
			mSx[k] = '0;
			mSy[k] = '0;
			for (int l = 0; l < 4; l++) mCol[l][k] = '0;
		end
		for (int k = 0; k < 4; k++) begin
			mSz[k]  = '0;
			mIr[k]  = '0;
			mMac[k] = '0;
		end
		mRgbc  = '0;
		mOtz   = '0;
		mFlags = '0;
		mLzcs  = '0;
	endtask

	// ------------------------------------------------------------
	// Reference model, one rising edge
	// ------------------------------------------------------------
	task automatic applyModel(input logic [5:0] id, input logic wr, input logic [31:0] d,
			input gteWb_t wb);
		logic       cpuPush;  // CPU SXYP push
		logic [3:0] cPush;
		logic [7:0] oldCode;  // RGBC code before this edge
		cpuPush = wr && (id == SXYP);
		cPush   = {wb.pushB, wb.pushB, wb.pushG, wb.pushR};
		oldCode = mRgbc[31:24];
		// Input vectors and LZCS
		if (wr && id <= 6'd5 && !id[0]) begin
			mVx[id / 2] = d[15:0];
			mVy[id / 2] = d[31:16];
		end
		if (wr && id <= 6'd5 && id[0]) mVz[id / 2] = d[15:0];
		if (wr && id == LZCS) mLzcs = d;
		// Screen FIFOs
		if (cpuPush || wb.pushX) begin
			mSx[0] = mSx[1];
			mSx[1] = mSx[2];
			mSx[2] = cpuPush ? d[15:0] : wb.xyV;
		end else if (wr && id >= SXY0 && id <= SXY2) begin
			mSx[id - SXY0] = d[15:0];
		end
		if (cpuPush || wb.pushY) begin
			mSy[0] = mSy[1];
			mSy[1] = mSy[2];
			mSy[2] = cpuPush ? d[31:16] : wb.xyV;
		end else if (wr && id >= SXY0 && id <= SXY2) begin
			mSy[id - SXY0] = d[31:16];
		end
		if (wb.pushZ) begin
			for (int k = 0; k < 3; k++) mSz[k] = mSz[k + 1];
			mSz[3] = wb.otzV;
		end else if (wr && id >= SZ0 && id <= SZP) begin
			mSz[id - SZ0] = d[15:0];
		end
		// Color lanes, code follows blue
		for (int l = 0; l < 4; l++) begin
			if (cPush[l]) begin
				mCol[l][0] = mCol[l][1];
				mCol[l][1] = mCol[l][2];
				mCol[l][2] = (l == 3) ? oldCode : wb.colV;
			end else if (wr && id >= RGB0 && id <= RGB2) begin
				mCol[l][id - RGB0] = d[8*l +: 8];
			end
		end
		if (wr && id == RGBC) mRgbc = d;
		// Results, writeback first
		for (int k = 0; k < 4; k++) begin
			if (wb.wrIr[k]) mIr[k] = (k == 0) ? wb.ir0 : wb.ir13;
			else if (wr && id == IRGB && k > 0) mIr[k] = {4'b0, d[5*(k-1) +: 5], 7'b0};
			else if (wr && id == IR0 + k) mIr[k] = d[15:0];
			if (wb.wrMac[k]) mMac[k] = (k == 0) ? wb.mac0 : wb.mac13;
			else if (wr && id == MAC0 + k) mMac[k] = d;
		end
		if (wb.wrOtz) mOtz = wb.otzV;
		else if (wr && id == OTZ) mOtz = d[15:0];
		if (wr && id == FLAGS) mFlags = d[30:12];  // CPU beats writeback here
		else if (wb.loadInstr) mFlags = wb.updateFlags;
		else mFlags = mFlags | wb.updateFlags;
	endtask

	function automatic logic [31:0] expRead(input logic [5:0] id);
		if (id[5]) return {(|mFlags[18:11]) | (|mFlags[6:1]), mFlags, 12'b0};
		case (id)
			6'd0, 6'd2, 6'd4:         return {mVy[id / 2], mVx[id / 2]};
			6'd1, 6'd3, 6'd5:         return {{16{mVz[id / 2][15]}}, mVz[id / 2]};
			6'd6:                     return mRgbc;
			6'd7:                     return {16'b0, mOtz};
			6'd8, 6'd9, 6'd10, 6'd11: return {{16{mIr[id - 8][15]}}, mIr[id - 8]};
			6'd12, 6'd13, 6'd14:      return {mSy[id - 12], mSx[id - 12]};
			6'd15:                    return {mSy[2], mSx[2]};  // Same as SXY2
			6'd16, 6'd17, 6'd18, 6'd19: return {16'b0, mSz[id - 16]};
			6'd20, 6'd21, 6'd22:
				return {mCol[3][id - 20], mCol[2][id - 20], mCol[1][id - 20], mCol[0][id - 20]};
			6'd24, 6'd25, 6'd26, 6'd27: return mMac[id - 24];
			6'd28, 6'd29: return {17'b0, clamp5(mIr[3]), clamp5(mIr[2]), clamp5(mIr[1])};
			6'd30:                    return mLzcs;
			6'd31:                    return leadCount(mLzcs);
			default:                  return 32'b0;
		endcase
	endfunction

	// ------------------------------------------------------------
	// Bus tasks
	// ------------------------------------------------------------
	task automatic drive(input logic [5:0] id, input logic wr, input logic [31:0] d,
			input gteWb_t wb);
		@(negedge clk);
		i_regId  = gteRegId_e'(id);
		i_wrReg  = wr;
		i_dataIn = d;
		i_wb     = wb;
		@(posedge clk);
		applyModel(id, wr, d, wb);
	endtask

	task automatic checkRead(input logic [5:0] id);
		logic [31:0] want;
		@(negedge clk);
		i_regId  = gteRegId_e'(id);
		i_wrReg  = 1'b0;
		i_dataIn = '0;
		i_wb     = '0;
		#2;
		want = expRead(id);
		nChecks++;
		assert (o_dataOut === want) else begin
			nErrors++;
			$display("** Error at %0t: ID %0d read %h, expected %h", $time, id, o_dataOut, want);
		end
	endtask

	task automatic checkAll();
		for (int id = 0; id < 32; id++) begin
			if (id != 23) checkRead(id);  // Old RES1 slot skipped
		end
		checkRead(6'd40);  // Other control ID, FLAGS word
		checkRead(FLAGS);
	endtask

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin
		gteWb_t      wb;
		logic [5:0]  rid;
		logic [31:0] edgeVals [4];
		lfsr     = 32'd354;
		nErrors  = 0;
		nChecks  = 0;
		cycles   = 0;
		i_regId  = VXY0;
		i_wrReg  = 1'b0;
		i_dataIn = '0;
		i_wb     = '0;
		clearModel();
		wait (rst === 1'b0);

		// Reset values, then plain CPU writes
		checkAll();
		for (int n = 0; n < 6; n++) drive(n, 1'b1, rnd(32), '0);
		for (int k = 0; k < 4; k++) begin
			drive(IR0 + k, 1'b1, rnd(32), '0);
			drive(MAC0 + k, 1'b1, rnd(32), '0);
		end
		drive(OTZ, 1'b1, 32'hffff_8001, '0);  // Must read zero-extended
		drive(IR2, 1'b1, 32'h0000_8001, '0);  // Must read sign-extended
		checkAll();

		// Screen FIFO pushes
		for (int n = 0; n < 8; n++) begin
			wb       = '0;
			wb.pushX = rnd(1) != 0;
			wb.pushY = rnd(1) != 0;
			wb.pushZ = rnd(1) != 0;
			wb.xyV   = rnd(16);
			wb.otzV  = rnd(16);
			drive(LZCR, 1'b0, '0, wb);
			checkRead(SXY2);
			checkRead(SZP);
		end
		drive(SXYP, 1'b1, rnd(32), '0);
		checkRead(SXYP);
		checkRead(SXY2);
		wb       = '0;
		wb.pushX = 1'b1;
		wb.xyV   = rnd(16);
		drive(SXYP, 1'b1, rnd(32), wb);  // CPU data wins the push
		drive(SXY0, 1'b1, rnd(32), '0);
		drive(SZ1, 1'b1, rnd(32), '0);
		drive(SZP, 1'b1, rnd(32), '0);
		drive(LZCR, 1'b0, '0, '0);
		drive(LZCR, 1'b0, '0, '0);  // Slots must hold
		checkAll();

		// Color FIFO, one channel at a time
		drive(RGBC, 1'b1, rnd(32), '0);
		for (int n = 0; n < 6; n++) begin
			wb       = '0;
			wb.pushR = (n % 3) == 0;
			wb.pushG = (n % 3) == 1;
			wb.pushB = (n % 3) == 2;
			wb.colV  = rnd(8);
			drive(LZCR, 1'b0, '0, wb);
			for (int k = 0; k < 3; k++) checkRead(RGB0 + k);
			if (n == 2) drive(RGBC, 1'b1, rnd(32), '0);  // New code for next blue push
		end
		drive(RGB1, 1'b1, rnd(32), '0);
		checkRead(RGB1);

		// FLAGS load, accumulate, reload
		drive(FLAGS, 1'b1, rnd(32), '0);
		checkRead(FLAGS);
		for (int n = 0; n < 4; n++) begin
			wb             = '0;
			wb.updateFlags = rnd(19) & rnd(19);  // Sparse bits
			drive(LZCR, 1'b0, '0, wb);
			checkRead(FLAGS);
		end
		wb             = '0;
		wb.loadInstr   = 1'b1;
		wb.updateFlags = 19'h00781;  // Bits 0 and 7..10, outside the summary
		drive(LZCR, 1'b0, '0, wb);
		checkRead(FLAGS);
		wb             = '0;
		wb.updateFlags = 19'h00008;
		drive(LZCR, 1'b0, '0, wb);
		checkRead(FLAGS);
		wb.loadInstr   = 1'b1;
		wb.updateFlags = 19'h08000;
		drive(LZCR, 1'b0, '0, wb);
		checkRead(6'd40);
		drive(FLAGS, 1'b1, 32'h4000_0000, wb);  // CPU write beats the reload
		checkRead(FLAGS);

		// IRGB expansion and ORGB clamp
		drive(IRGB, 1'b1, rnd(32), '0);
		for (int k = 1; k < 4; k++) checkRead(IR0 + k);
		checkRead(IRGB);
		drive(IR1, 1'b1, 32'h0000_8000, '0);
		drive(IR2, 1'b1, 32'h0000_7fff, '0);
		drive(IR3, 1'b1, 32'h0000_0a80, '0);
		checkRead(ORGB);
		drive(IR1, 1'b1, 32'h0000_ff80, '0);  // -128, just below zero
		drive(IR2, 1'b1, 32'h0000_0f80, '0);  // Exactly 31
		drive(IR3, 1'b1, 32'h0000_1000, '0);  // 32, clamps
		checkRead(ORGB);
		checkRead(IRGB);

		// Leading count
		edgeVals[0] = 32'h0000_0000;
		edgeVals[1] = 32'hffff_ffff;
		edgeVals[2] = 32'h0000_0001;
		edgeVals[3] = 32'h8000_0000;
		for (int n = 0; n < 12; n++) begin
			drive(LZCS, 1'b1, (n < 4) ? edgeVals[n] : (rnd(32) >> rnd(5)), '0);
			checkRead(LZCS);
			checkRead(LZCR);
		end

		// Writeback against CPU on the same MAC1 edge
		wb       = '0;
		wb.wrMac = 4'b0010;
		wb.mac13 = rnd(32);
		drive(MAC1, 1'b1, rnd(32), wb);
		checkRead(MAC1);

		// Mixed random traffic
		for (int n = 0; n < 24; n++) begin
			rid = (rnd(3) == 0) ? 6'd63 : 6'(rnd(5));
			drive(rid, rnd(1) != 0, rnd(32), randWb());
		end
		checkAll();

		$display("Checks run: %0d, errors: %0d", nChecks, nErrors);
		if (nErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* all.f */
common/gtePkg.sv
source/gteShiftFifo.sv
source/gteRegDecode.sv
screen/gteScreenFifo.sv
color/gteColorFifo.sv
source/gteResultRegs.sv
source/gteInputRegs.sv
source/gteReadMux.sv
source/gteRegFile.sv
dv/tbClock.sv
dv/gteRegFileTb.sv

/* Bender.yml */
package:
  name: gte_reg_file

sources:
  - common/gtePkg.sv
  - source/gteShiftFifo.sv
  - source/gteRegDecode.sv
  - screen/gteScreenFifo.sv
  - color/gteColorFifo.sv
  - source/gteResultRegs.sv
  - source/gteInputRegs.sv
  - source/gteReadMux.sv
  - source/gteRegFile.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/gteRegFileTb.sv
